//--- tb/adc_capture_stimulus.txt
# columns: command then decimal arguments, one command per line
# capture H | status C F N | expect A K | kept A K | idle N | random N
# K counts edges from the first enabled edge of the last capture, or for kept the one before
idle 2
status 0 0 0
capture 20
status 0 0 20
expect 0 4
expect 1 5
expect 2 6
expect 3 7
expect 4 8
expect 5 9
expect 6 10
expect 7 11
expect 8 12
expect 9 13
expect 10 14
expect 11 15
expect 12 16
expect 13 17
expect 14 18
expect 15 19
expect 16 20
expect 17 21
expect 18 22
expect 19 23
idle 3
capture 1100
status 0 1 1024
expect 0 4
expect 1 5
expect 2 6
expect 3 7
expect 4 8
expect 5 9
expect 8 12
expect 10 14
expect 15 19
expect 16 20
expect 20 24
expect 31 35
expect 32 36
expect 63 67
expect 64 68
expect 100 104
expect 127 131
expect 128 132
expect 200 204
expect 255 259
expect 256 260
expect 300 304
expect 333 337
expect 383 387
expect 384 388
expect 400 404
expect 450 454
expect 500 504
expect 511 515
expect 512 516
expect 513 517
expect 600 604
expect 640 644
expect 700 704
expect 767 771
expect 768 772
expect 800 804
expect 850 854
expect 900 904
expect 950 954
expect 999 1003
expect 1000 1004
expect 1001 1005
expect 1010 1014
expect 1015 1019
expect 1019 1023
expect 1020 1024
expect 1021 1025
expect 1022 1026
expect 1023 1027
random 40
idle 2
capture 12
status 0 0 12
expect 0 4
expect 1 5
expect 2 6
expect 3 7
expect 4 8
expect 5 9
expect 6 10
expect 7 11
expect 8 12
expect 9 13
expect 10 14
expect 11 15
kept 12 16
kept 13 17
kept 19 23
kept 20 24
kept 64 68
kept 128 132
kept 256 260
kept 511 515
kept 512 516
kept 777 781
kept 1000 1004
kept 1023 1027
random 64
idle 4
status 0 0 12

//--- adc_capture_top.f
+incdir+hdl
hdl/adc_capture_pkg.sv
hdl/capture_buffer.sv
hdl/capture_sequencer.sv
hdl/adc_capture_top.sv
tb/adc_capture_tb.sv

//--- Makefile
# Verilator build and run of the ADC capture testbench.
# The run passes only when the pass message appears in the simulation output.

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := adc_capture_tb
FILELIST  := adc_capture_top.f
BUILD_DIR := build

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(BUILD_DIR)

//--- tb/adc_capture_tb.sv
// Testbench for the ADC capture path.
// Runs the commands of the stimulus file against adc_capture_top: captures,
// status checks and readback of both capture memories. Expected words are
// recomputed from the edge index at which they were driven.

`timescale 1ns/1ns
`default_nettype none

`include "adc_capture_macros.svh"

module adc_capture_tb
	import adc_capture_pkg::*;
;

	localparam logic [31:0] SEED = 32'h190a_9796;
	localparam string STIM_FILE = "tb/adc_capture_stimulus.txt";
	localparam int DEPTH = 1 << `CAPTURE_ADDR_BITS;
	localparam int RESET_CYCLES = 3;
	localparam int LOW_CYCLES = 8;
	localparam int LIMIT_MARGIN = 64;

	logic            data_clk_div = 1'b0;
	logic            rst_n;
	logic            enable_bram;
	adc_sample_t     adc_sample;
	raw_lanes_t      raw_lanes;
	capture_addr_t   rd_addr;
	adc_sample_t     sample_rd_data;
	raw_lanes_t      raw_rd_data;
	capture_status_t status;

	int          edge_count = 0;
	int          cycle_count = 0;
	int          cycle_limit = 1000;
	int          last_first = 0;
	int          prev_first = 0;
	int          last_words = 0;
	int          src_idx [DEPTH];
	logic [31:0] rng_state = SEED;
	int          sample_errors = 0;
	int          raw_errors = 0;
	int          status_errors = 0;
	int          other_errors = 0;

	adc_capture_top adc_capture_top_inst (
		.data_clk_div   (data_clk_div),
		.rst_n          (rst_n),
		.enable_bram    (enable_bram),
		.adc_sample     (adc_sample),
		.raw_lanes      (raw_lanes),
		.rd_addr        (rd_addr),
		.sample_rd_data (sample_rd_data),
		.raw_rd_data    (raw_rd_data),
		.status         (status)
	);

	always #20 data_clk_div = ~data_clk_div;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// never zero, or xorshift would stay stuck
	function automatic logic [31:0] edge_seed(input logic [31:0] idx);
		logic [31:0] x;
		x = SEED ^ (idx * 32'h9e37_79b9);
		if (x == 32'd0) begin
			x = SEED;
		end
		return x;
	endfunction

	// words sampled by the DUT at edge idx
	function automatic adc_sample_t sample_at(input logic [31:0] idx);
		return adc_sample_t'(xorshift32(xorshift32(edge_seed(idx))));
	endfunction

	function automatic raw_lanes_t raw_at(input logic [31:0] idx);
		return raw_lanes_t'(xorshift32(xorshift32(xorshift32(edge_seed(idx)))));
	endfunction

	// status just after edge E+t of a capture of n words
	function automatic capture_status_t status_at(input int t, input int n);
		capture_status_t s;
		int w;
		if (t < 3) begin
			w = last_words;
		end else if (t - 3 < n) begin
			w = t - 3;
		end else begin
			w = n;
		end
		s.capturing = (t >= 3) && (t <= n + 2);
		s.full = (w == DEPTH);
		s.words_written = w[`CAPTURE_ADDR_BITS:0];
		return s;
	endfunction

	// new words every cycle, one index per edge
	initial begin
		adc_sample = sample_at(32'd1);
		raw_lanes = raw_at(32'd1);
		forever begin
			@(posedge data_clk_div);
			edge_count++;
			#2;
			adc_sample = sample_at(edge_count + 1);
			raw_lanes = raw_at(edge_count + 1);
		end
	end

	task automatic step();
		@(posedge data_clk_div);
		#2;
	endtask

	task automatic print_counts();
		$display("errors: sample %0d, raw %0d, status %0d, other %0d",
			sample_errors, raw_errors, status_errors, other_errors);
	endtask

	task automatic check_sample(input int addr, input adc_sample_t got, input adc_sample_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED sample_rd_data at address 0x%0h: got %h, expected %h",
				addr, got, exp);
			sample_errors++;
		end
	endtask

	task automatic check_raw(input int addr, input raw_lanes_t got, input raw_lanes_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED raw_rd_data at address 0x%0h: got %h, expected %h",
				addr, got, exp);
			raw_errors++;
		end
	endtask

	task automatic check_status(input capture_status_t got, input capture_status_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED status: got %h, expected %h", got, exp);
			status_errors++;
		end
	endtask

	// data is back one edge after the address
	task automatic read_word(input int addr);
		rd_addr = capture_addr_t'(addr);
		step();
	endtask

	task automatic check_entry(input int addr, input int idx);
		read_word(addr);
		check_sample(addr, sample_rd_data, sample_at(idx));
		check_raw(addr, raw_rd_data, raw_at(idx));
	endtask

	task automatic run_capture(input int hold);
		int n;
		prev_first = last_first;
		n = (hold < DEPTH) ? hold : DEPTH;
		enable_bram = 1'b1;
		last_first = edge_count + 1;
		// status after every edge of the capture and of the low time
		for (int t = 0; t < hold + LOW_CYCLES; t++) begin
			step();
			check_status(status, status_at(t, n));
			if (t == hold - 1) begin
				enable_bram = 1'b0;
			end
		end
		last_words = n;
		// first word lands four edges after the enable is first seen
		for (int a = 0; a < n; a++) begin
			src_idx[a] = last_first + 4 + a;
		end
	endtask

	task automatic run_random(input int count);
		int addr;
		repeat (count) begin
			rng_state = xorshift32(rng_state);
			addr = int'(rng_state[`CAPTURE_ADDR_BITS-1:0]);
			if (src_idx[addr] < 0) begin
				read_word(addr);
			end else begin
				check_entry(addr, src_idx[addr]);
			end
		end
	endtask

	function automatic int arg_count(input string cmd);
		if (cmd == "capture" || cmd == "idle" || cmd == "random") begin
			return 1;
		end else if (cmd == "expect" || cmd == "kept") begin
			return 2;
		end else if (cmd == "status") begin
			return 3;
		end
		return -1;
	endfunction

	function automatic int command_cycles(input string cmd, input int a);
		if (cmd == "capture") begin
			return a + LOW_CYCLES + 1;
		end else if (cmd == "idle" || cmd == "random") begin
			return a;
		end else if (cmd == "expect" || cmd == "kept") begin
			return 1;
		end
		return 0;
	endfunction

	task automatic run_command(input string cmd, input int a, input int b, input int c);
		capture_status_t exp_status;
		if (cmd == "capture") begin
			run_capture(a);
		end else if (cmd == "idle") begin
			repeat (a) step();
		end else if (cmd == "random") begin
			run_random(a);
		end else if (cmd == "expect") begin
			check_entry(a, last_first + b);
		end else if (cmd == "kept") begin
			check_entry(a, prev_first + b);
		end else begin
			exp_status.capturing = (a != 0);
			exp_status.full = (b != 0);
			exp_status.words_written = c[`CAPTURE_ADDR_BITS:0];
			check_status(status, exp_status);
		end
	endtask

	// first pass only sums cycles for the watchdog
	task automatic run_file(input bit count_only);
		int fd;
		int ch;
		int nargs;
		int got;
		int arg_a;
		int arg_b;
		int arg_c;
		string cmd;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0) begin
			if (!count_only) begin
				$display("cannot open the stimulus file %s", STIM_FILE);
				other_errors++;
			end
			return;
		end
		while ($fscanf(fd, "%s", cmd) == 1) begin
			nargs = arg_count(cmd);
			got = 0;
			if (nargs > 0 && $fscanf(fd, "%d", arg_a) == 1) got++;
			if (nargs > 1 && $fscanf(fd, "%d", arg_b) == 1) got++;
			if (nargs > 2 && $fscanf(fd, "%d", arg_c) == 1) got++;
			if (cmd == "#") begin
				ch = $fgetc(fd);
				while (ch != 10 && ch != -1) begin
					ch = $fgetc(fd);
				end
			end else if (nargs < 0 || got != nargs) begin
				if (!count_only) begin
					$display("stimulus line starting with '%s' could not be parsed", cmd);
					other_errors++;
				end
				break;
			end else if (count_only) begin
				cycle_limit += command_cycles(cmd, arg_a);
			end else begin
				run_command(cmd, arg_a, arg_b, arg_c);
			end
		end
		$fclose(fd);
	endtask

	initial begin
		while (cycle_count < cycle_limit) begin
			@(posedge data_clk_div);
			cycle_count++;
		end
		$display("timeout: the run did not end within %0d clock cycles", cycle_limit);
		print_counts();
		$display("Test failed");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		enable_bram = 1'b0;
		rd_addr = '0;
		for (int a = 0; a < DEPTH; a++) begin
			src_idx[a] = -1;
		end
		cycle_limit = RESET_CYCLES + LIMIT_MARGIN;
		run_file(1'b1);
		repeat (RESET_CYCLES) @(posedge data_clk_div);
		#2;
		rst_n = 1'b1;
		run_file(1'b0);
		print_counts();
		if (sample_errors + raw_errors + status_errors + other_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/adc_capture_top.sv
// Top level of the ADC capture path.
// The sequencer turns the capture enable into write commands, which both
// capture buffers take on the next edge together with the current words.
// The sample buffer keeps the two ADC channel words, the raw buffer keeps
// the four lane words for debug. Both are read through rd_addr.

`timescale 1ns/1ns
`default_nettype none

`include "adc_capture_macros.svh"

module adc_capture_top
	import adc_capture_pkg::*;
(
	input  logic            data_clk_div,
	input  logic            rst_n,
	input  logic            enable_bram,
	input  adc_sample_t     adc_sample,
	input  raw_lanes_t      raw_lanes,
	input  capture_addr_t   rd_addr,
	output adc_sample_t     sample_rd_data,
	output raw_lanes_t      raw_rd_data,
	output capture_status_t status
);

	// shared by both buffers so equal addresses hold words of the same edge
	write_cmd_t write_cmd;

	capture_sequencer capture_sequencer_inst (
		.data_clk_div (data_clk_div),
		.rst_n        (rst_n),
		.enable_bram  (enable_bram),
		.write_cmd    (write_cmd),
		.status       (status)
	);

	// deserialized channel words
	capture_buffer #(
		.payload_t (adc_sample_t)
	) sample_buffer_inst (
		.data_clk_div (data_clk_div),
		.write_cmd    (write_cmd),
		.wr_data      (adc_sample),
		.rd_addr      (rd_addr),
		.rd_data      (sample_rd_data)
	);

	// raw lane words for debug
	capture_buffer #(
		.payload_t (raw_lanes_t)
	) raw_buffer_inst (
		.data_clk_div (data_clk_div),
		.write_cmd    (write_cmd),
		.wr_data      (raw_lanes),
		.rd_addr      (rd_addr),
		.rd_data      (raw_rd_data)
	);

endmodule

`default_nettype wire

//--- hdl/capture_sequencer.sv
// Capture sequencer of the ADC capture path.
// Synchronizes the asynchronous capture enable, arms on its rising edge and
// then issues one memory write per cycle from address 0 until the enable
// falls or the last address has been written. Also keeps the capture status.

`timescale 1ns/1ns
`default_nettype none

`include "adc_capture_macros.svh"

module capture_sequencer
	import adc_capture_pkg::*;
(
	input  logic            data_clk_div,
	input  logic            rst_n,
	input  logic            enable_bram,
	output write_cmd_t      write_cmd,
	output capture_status_t status
);

	logic [`ENABLE_SYNC_STAGES-1:0] enable_sync;
	logic                           enable_level;
	logic                           enable_level_d;
	logic                           enable_rise;
	logic                           enable_fall;
	logic                           armed;
	logic                           armed_next;
	logic [`CAPTURE_ADDR_BITS:0]    issue_count;
	logic [`CAPTURE_ADDR_BITS:0]    issue_base;
	logic                           issue;
	write_cmd_t                     cmd_q;
	logic                           full_q;
	logic [`CAPTURE_ADDR_BITS:0]    words_q;

	assign enable_level = enable_sync[`ENABLE_SYNC_STAGES-1];
	assign enable_rise = enable_level & ~enable_level_d;
	assign enable_fall = ~enable_level & enable_level_d;

	// a rising edge arms on the same cycle, so the first write is not delayed
	assign armed_next = enable_rise | (armed & ~enable_fall);

	// a new capture restarts from address 0
	assign issue_base = enable_rise ? '0 : issue_count;

	// top bit set once all addresses have been issued
	assign issue = armed_next & ~issue_base[`CAPTURE_ADDR_BITS];

	// enable synchronizer and edge detect
	always_ff @(posedge data_clk_div) begin
		if (!rst_n) begin
			enable_sync <= '0;
			enable_level_d <= 1'b0;
			armed <= 1'b0;
		end else begin
			enable_sync <= {enable_sync[`ENABLE_SYNC_STAGES-2:0], enable_bram};
			enable_level_d <= enable_level;
			armed <= armed_next;
		end
	end

	// write command, one stage ahead of the memories
	always_ff @(posedge data_clk_div) begin
		if (!rst_n) begin
			cmd_q <= '0;
			issue_count <= '0;
		end else begin
			cmd_q.wr_en <= issue;
			if (issue) begin
				cmd_q.addr <= issue_base[`CAPTURE_ADDR_BITS-1:0];
				issue_count <= issue_base + 1'b1;
			end
		end
	end

	// status follows the writes the buffers actually perform
	always_ff @(posedge data_clk_div) begin
		if (!rst_n) begin
			full_q <= 1'b0;
			words_q <= '0;
		end else if (enable_rise) begin
			full_q <= 1'b0;
			words_q <= '0;
		end else if (cmd_q.wr_en) begin
			words_q <= words_q + 1'b1;
			if (cmd_q.addr == '1) begin
				full_q <= 1'b1;
			end
		end
	end

	assign write_cmd = cmd_q;

	// capturing is the write enable seen by the memories
	assign status.capturing = cmd_q.wr_en;
	assign status.full = full_q;
	assign status.words_written = words_q;

endmodule

`default_nettype wire

//--- hdl/capture_buffer.sv
// One capture memory of the ADC capture path.
// Writes the payload at the command address when the command enables it,
// and returns the word at rd_addr one cycle later. A read of the address
// being written in the same cycle returns the old word.
// The payload type is set per instance.

`timescale 1ns/1ns
`default_nettype none

`include "adc_capture_macros.svh"

module capture_buffer
	import adc_capture_pkg::*;
#(
	parameter type payload_t = adc_sample_t
) (
	input  logic          data_clk_div,
	input  write_cmd_t    write_cmd,
	input  payload_t      wr_data,
	input  capture_addr_t rd_addr,
	output payload_t      rd_data
);

	localparam int DEPTH = 1 << `CAPTURE_ADDR_BITS;

	payload_t mem [DEPTH];
	payload_t rd_data_q;

	// write port
	always_ff @(posedge data_clk_div) begin
		if (write_cmd.wr_en) begin
			mem[write_cmd.addr] <= wr_data;
		end
	end

	// registered read, sees the contents before this cycle's write
	always_ff @(posedge data_clk_div) begin
		rd_data_q <= mem[rd_addr];
	end

	assign rd_data = rd_data_q;

endmodule

`default_nettype wire

//--- hdl/adc_capture_pkg.sv
// Types shared by the ADC capture sequencer, the capture buffers and the top level.
// Import it with a wildcard import in the module header.

`default_nettype none

`include "adc_capture_macros.svh"

package adc_capture_pkg;

	// raw word types, one per sample channel and one per lane
	typedef logic [`ADC_SAMPLE_BITS-1:0] adc_word_t;
	typedef logic [`RAW_LANE_BITS-1:0] lane_word_t;

	// address into either capture memory
	typedef logic [`CAPTURE_ADDR_BITS-1:0] capture_addr_t;

	// channel 0 sits in the upper half
	typedef struct packed {
		adc_word_t ch0;
		adc_word_t ch1;
	} adc_sample_t;

	// lane 0 most significant
	typedef struct packed {
		lane_word_t lane0;
		lane_word_t lane1;
		lane_word_t lane2;
		lane_word_t lane3;
	} raw_lanes_t;

	// one write per cycle, shared by both memories
	typedef struct packed {
		logic          wr_en;
		capture_addr_t addr;
	} write_cmd_t;

	// words_written needs one extra bit to reach the full depth
	typedef struct packed {
		logic                         capturing;
		logic                         full;
		logic [`CAPTURE_ADDR_BITS:0]  words_written;
	} capture_status_t;

endpackage

`default_nettype wire

//--- hdl/adc_capture_macros.svh
// Shared constants of the ADC capture path.
// Include this header in any file that sizes a sample, a lane word or a
// capture memory address. The include guard makes repeated inclusion harmless.

`ifndef ADC_CAPTURE_MACROS_SVH
`define ADC_CAPTURE_MACROS_SVH

// one deserialized ADC channel word
`define ADC_SAMPLE_BITS 16

// channels packed into one capture word
`define ADC_CHANNELS 2

// one raw deserializer lane word, kept for debug
`define RAW_LANE_BITS 8

// raw lanes packed into one debug word
`define RAW_LANES 4

// 10 address bits give 1024 words per capture memory
`define CAPTURE_ADDR_BITS 10

// flops between the asynchronous enable and the capture logic
`define ENABLE_SYNC_STAGES 3

`endif
